//--- dv/exu_ecl_testdata.txt
# hex, one line per cycle: flags rs1 rs2 rf_a rf_b imm rd exccode alu_res link_pc rdata,
# then expected: flags exccode alu_a alu_b lsu_offset wr_rd wr_data (rd feeds rf_target, lsu_rd)
# stimulus flags msb first: valid b_imm double_read alu_wen / bru_valid lsu_valid lsu_wen
#   exception / bru_taken bru_wen data_valid wr_fin / ale timer ext ie
# expected flags: lsu_req_valid bru_valid br_taken except / stall_req rf_wr_wen 0 0
9000 02 03 0020 0030 0000 01 00 0111 0000 0000  00 00 0020 0030 0000 00 0000
9000 01 00 0aaa 0bbb 0000 02 00 0222 0000 0000  00 00 0111 0bbb 0000 00 0000
9000 01 02 00a1 00b2 0000 03 00 0333 0000 0000  04 00 0111 0222 0000 01 0111
d000 01 03 00c1 00c3 0044 00 00 00f0 0000 0000  04 00 00c1 00c3 0044 02 0222
a000 00 03 0000 00b3 0055 04 00 0999 0000 0000  04 00 0000 00b3 00b3 03 0333
88c0 02 03 00a2 00b3 0000 05 00 0777 1004 0000  64 00 00a2 00b3 0000 00 00f0
8800 05 00 00a5 00b0 0000 06 00 0888 2008 0000  40 00 1004 00b0 0000 00 0000
c600 05 00 00a5 00b7 0010 07 00 0000 0000 0000  8c 00 1004 00b7 0010 05 1004
0000 00 00 0000 0000 0000 00 00 0000 0000 0000  08 00 0000 0000 0000 00 0000
0000 00 00 0000 0000 0000 00 00 0000 0000 0000  08 00 0000 0000 0000 00 0000
0000 00 00 0000 0000 0000 00 00 0000 0000 0000  08 00 0000 0000 0000 00 0000
0020 07 00 00a7 0000 0000 00 00 0000 0000 5a5a  08 00 5a5a 0000 0000 00 0000
a400 07 02 00a7 0062 0000 00 00 0000 0000 0000  8c 00 5a5a 0062 0062 07 5a5a
0000 00 00 0000 0000 0000 00 00 0000 0000 0000  08 00 0000 0000 0000 00 0000
0010 00 00 0000 0000 0000 00 00 0000 0000 0000  08 00 0000 0000 0000 00 0000
c600 00 00 0100 0000 0003 09 09 0000 0000 0000  88 09 0100 0000 0003 00 0000
8008 00 00 0000 0000 0000 00 09 0000 0000 0000  18 09 0000 0000 0000 00 0000
0005 00 00 0000 0000 0000 00 00 0000 0000 0000  00 00 0000 0000 0000 00 0000
9ec5 00 00 0000 0000 0000 0a 0e 0bad 0c0c 0000  10 00 0000 0000 0000 00 0000
8003 00 00 0000 0000 0000 00 00 0000 0000 0000  00 00 0000 0000 0000 00 0000
0003 00 00 0000 0000 0000 00 00 0000 0000 0000  00 00 0000 0000 0000 00 0000
9103 00 00 0000 0000 0000 0b 05 0bee 0000 0000  10 00 0000 0000 0000 00 0000
0004 00 00 0000 0000 0000 00 00 0000 0000 0000  00 00 0000 0000 0000 00 0000
88c4 00 00 0000 0000 0000 0c 00 0000 3000 0000  60 00 0000 0000 0000 00 0000
0000 00 00 0000 0000 0000 00 00 0000 0000 0000  00 00 0000 0000 0000 00 0000
0000 00 00 0000 0000 0000 00 00 0000 0000 0000  04 00 0000 0000 0000 0c 3000

//--- all.f
verilog/exu_pkg.sv
verilog/exu_bypass.sv
verilog/exu_lsu_track.sv
verilog/exu_trap.sv
verilog/exu_writeback.sv
verilog/exu_ecl.sv
dv/tb_exu_ecl.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build with verilator from all.f, run, and pass only on the testbench pass line
cd "$(dirname "$0")" || exit 1
verilator --binary --assert --top-module tb_exu_ecl -f all.f -o sim_exu_ecl \
   && ./obj_dir/sim_exu_ecl | tee /dev/stderr | grep -qx "TESTBENCH PASSED" \
   && echo "simulation passed" \
   || { echo "simulation failed"; exit 1; }

//--- dv/tb_exu_ecl.sv
`timescale 1ns/1ps

module tb_exu_ecl;

   localparam int clk_period   = 40;
   localparam int drive_delay  = 2;
   localparam int sample_delay = clk_period - drive_delay - 2;
   localparam int reset_cycles = 16;
   // bound on vector file length
   localparam int max_lines    = 200;
   localparam int field_count  = 18;

   logic                        clk;
   logic                        reset;
   exu_pkg::exu_issue_t         issue;
   logic [exu_pkg::grlen-1:0]   alu_res;
   logic                        bru_taken;
   logic [exu_pkg::grlen-1:0]   bru_link_pc;
   logic                        bru_wen;
   exu_pkg::lsu_resp_t          lsu_resp;
   exu_pkg::intr_t              intr;
   logic [exu_pkg::grlen-1:0]   alu_a;
   logic [exu_pkg::grlen-1:0]   alu_b;
   exu_pkg::lsu_req_t           lsu_req;
   logic                        bru_valid;
   logic                        br_taken;
   exu_pkg::trap_t              trap;
   logic                        stall_req;
   exu_pkg::rf_write_t          rf_wr;

   // stimulus fields of the current line
   logic [31:0] st_flags, st_rs1, st_rs2, st_rf_a, st_rf_b, st_imm;
   logic [31:0] st_rd, st_exc, st_alu_res, st_link, st_rdata;
   // expected fields of the current line
   logic [31:0] ex_flags, ex_exc, ex_alu_a, ex_alu_b, ex_offset, ex_rd, ex_data;

   int errors;
   int vectors;
   int line_no;

   exu_ecl dut (
      .clk         (clk),
      .reset       (reset),
      .issue       (issue),
      .alu_res     (alu_res),
      .bru_taken   (bru_taken),
      .bru_link_pc (bru_link_pc),
      .bru_wen     (bru_wen),
      .lsu_resp    (lsu_resp),
      .intr        (intr),
      .alu_a       (alu_a),
      .alu_b       (alu_b),
      .lsu_req     (lsu_req),
      .bru_valid   (bru_valid),
      .br_taken    (br_taken),
      .trap        (trap),
      .stall_req   (stall_req),
      .rf_wr       (rf_wr)
   );

   initial begin
      clk = 1'b0;
      forever #(clk_period / 2) clk = ~clk;
   end

   ////////////////////////////////////////////////////////////
   // drive and compare
   ////////////////////////////////////////////////////////////

   task automatic drive_idle();
      issue       = '0;
      alu_res     = '0;
      bru_taken   = 1'b0;
      bru_link_pc = '0;
      bru_wen     = 1'b0;
      lsu_resp    = '0;
      intr        = '0;
   endtask

   // flag word msb first, see the vector file header
   task automatic apply_vector();
      issue.valid         = st_flags[15];
      issue.b_imm         = st_flags[14];
      issue.double_read   = st_flags[13];
      issue.alu_wen       = st_flags[12];
      issue.bru_valid     = st_flags[11];
      issue.lsu_valid     = st_flags[10];
      issue.lsu_wen       = st_flags[9];
      issue.exception     = st_flags[8];
      bru_taken           = st_flags[7];
      bru_wen             = st_flags[6];
      lsu_resp.data_valid = st_flags[5];
      lsu_resp.wr_fin     = st_flags[4];
      lsu_resp.ale        = st_flags[3];
      intr.timer          = st_flags[2];
      intr.ext            = st_flags[1];
      intr.ie             = st_flags[0];
      issue.rs1           = st_rs1[exu_pkg::reg_addr_w-1:0];
      issue.rs2           = st_rs2[exu_pkg::reg_addr_w-1:0];
      issue.rf_a          = st_rf_a;
      issue.rf_b          = st_rf_b;
      issue.imm_shifted   = st_imm;
      // one rd column feeds both target fields
      issue.rf_target     = st_rd[exu_pkg::reg_addr_w-1:0];
      issue.lsu_rd        = st_rd[exu_pkg::reg_addr_w-1:0];
      issue.exccode       = st_exc[exu_pkg::exccode_w-1:0];
      alu_res             = st_alu_res;
      bru_link_pc         = st_link;
      lsu_resp.rdata      = st_rdata;
   endtask

   task automatic report_mismatch(string what, logic [31:0] got, logic [31:0] want);
      errors++;
      $display("[ERROR] %0t ns: vector line %0d, %s is %h, expected %h",
               $time, line_no, what, got, want);
   endtask

   task automatic check_vector();
      vectors++;
      if (alu_a !== ex_alu_a)
         report_mismatch("alu_a", alu_a, ex_alu_a);
      if (alu_b !== ex_alu_b)
         report_mismatch("alu_b", alu_b, ex_alu_b);
      if (lsu_req.valid !== ex_flags[7])
         report_mismatch("lsu_req.valid", 32'(lsu_req.valid), 32'(ex_flags[7]));
      if (lsu_req.base !== ex_alu_a)
         report_mismatch("lsu_req.base", lsu_req.base, ex_alu_a);
      if (lsu_req.offset !== ex_offset)
         report_mismatch("lsu_req.offset", lsu_req.offset, ex_offset);
      if (lsu_req.wdata !== ex_alu_b)
         report_mismatch("lsu_req.wdata", lsu_req.wdata, ex_alu_b);
      if (bru_valid !== ex_flags[6])
         report_mismatch("bru_valid", 32'(bru_valid), 32'(ex_flags[6]));
      if (br_taken !== ex_flags[5])
         report_mismatch("br_taken", 32'(br_taken), 32'(ex_flags[5]));
      if (trap.except !== ex_flags[4])
         report_mismatch("trap.except", 32'(trap.except), 32'(ex_flags[4]));
      if (trap.exccode !== ex_exc[exu_pkg::exccode_w-1:0])
         report_mismatch("trap.exccode", 32'(trap.exccode), ex_exc);
      if (stall_req !== ex_flags[3])
         report_mismatch("stall_req", 32'(stall_req), 32'(ex_flags[3]));
      if (rf_wr.wen !== ex_flags[2])
         report_mismatch("rf_wr.wen", 32'(rf_wr.wen), 32'(ex_flags[2]));
      // rd and data only mean something with wen
      if (ex_flags[2] && rf_wr.rd !== ex_rd[exu_pkg::reg_addr_w-1:0])
         report_mismatch("rf_wr.rd", 32'(rf_wr.rd), ex_rd);
      if (ex_flags[2] && rf_wr.data !== ex_data)
         report_mismatch("rf_wr.data", rf_wr.data, ex_data);
   endtask

   ////////////////////////////////////////////////////////////
   // main sequence
   ////////////////////////////////////////////////////////////

   initial begin
      string line;
      int    fd;
      int    n;
      int    cycles;
      bit    done;
      bit    timed_out;
      errors    = 0;
      vectors   = 0;
      line_no   = 0;
      done      = 1'b0;
      timed_out = 1'b0;
      reset     = 1'b1;
      drive_idle();
      fd = $fopen("dv/exu_ecl_testdata.txt", "r");
      if (fd == 0) begin
         $display("could not open the vector file dv/exu_ecl_testdata.txt");
         errors++;
         done = 1'b1;
      end
      // reset window, bounded by its own count
      cycles = 0;
      while (cycles < reset_cycles) begin
         @(posedge clk);
         cycles++;
      end
      #(drive_delay);
      reset = 1'b0;
      // one vector per cycle until the file ends
      while (!done) begin
         if (line_no >= max_lines) begin
            $display("timeout: vector file not finished after %0d lines", max_lines);
            timed_out = 1'b1;
            done = 1'b1;
         end else if ($fgets(line, fd) == 0) begin
            done = 1'b1;
         end else begin
            line_no++;
            if (line.len() > 1 && line.getc(0) != "#") begin
               n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                           st_flags, st_rs1, st_rs2, st_rf_a, st_rf_b, st_imm, st_rd,
                           st_exc, st_alu_res, st_link, st_rdata, ex_flags, ex_exc,
                           ex_alu_a, ex_alu_b, ex_offset, ex_rd, ex_data);
               if (n != field_count) begin
                  $display("vector line %0d is malformed, %0d fields read", line_no, n);
                  errors++;
               end else begin
                  apply_vector();
                  #(sample_delay);
                  check_vector();
                  @(posedge clk);
                  #(drive_delay);
               end
            end
         end
      end
      if (fd != 0)
         $fclose(fd);
      $display("vectors checked: %0d, errors: %0d", vectors, errors);
      if (errors == 0 && !timed_out && vectors > 0) begin
         $display("TESTBENCH PASSED");
      end else begin
         $display("TESTBENCH FAILED");
      end
      $finish;
   end

endmodule

//--- verilog/exu_ecl.sv
`timescale 1ns/1ps

module exu_ecl (
   input  logic                              clk,
   input  logic                              reset,
   input  exu_pkg::exu_issue_t               issue,
   input  logic [exu_pkg::grlen-1:0]         alu_res,
   input  logic                              bru_taken,
   input  logic [exu_pkg::grlen-1:0]         bru_link_pc,
   input  logic                              bru_wen,
   input  exu_pkg::lsu_resp_t                lsu_resp,
   input  exu_pkg::intr_t                    intr,
   output logic [exu_pkg::grlen-1:0]         alu_a,
   output logic [exu_pkg::grlen-1:0]         alu_b,
   output exu_pkg::lsu_req_t                 lsu_req,
   output logic                              bru_valid,
   output logic                              br_taken,
   output exu_pkg::trap_t                    trap,
   output logic                              stall_req,
   output exu_pkg::rf_write_t                rf_wr
);

   logic                              kill;
   exu_pkg::rf_write_t                rf_m;
   exu_pkg::rf_write_t                rf_w;
   logic [exu_pkg::reg_addr_w-1:0]    lsu_rd_m;
   logic                              lsu_wen_m;

   ////////////////////////////////////////////////////////////
   // interrupt and exception
   ////////////////////////////////////////////////////////////

   exu_trap u_trap (
      .clk     (clk),
      .reset   (reset),
      .issue   (issue),
      .intr    (intr),
      .lsu_ale (lsu_resp.ale),
      .trap    (trap),
      .kill    (kill)
   );

   ////////////////////////////////////////////////////////////
   // bypass
   ////////////////////////////////////////////////////////////

   exu_bypass u_bypass (
      .issue (issue),
      .rf_m  (rf_m),
      .rf_w  (rf_w),
      .alu_a (alu_a),
      .alu_b (alu_b)
   );

   // branch gated by kill
   assign bru_valid = issue.bru_valid & ~kill;
   assign br_taken  = bru_valid & bru_taken;

   ////////////////////////////////////////////////////////////
   // load/store tracking
   ////////////////////////////////////////////////////////////

   exu_lsu_track u_lsu_track (
      .clk       (clk),
      .reset     (reset),
      .issue     (issue),
      .kill      (kill),
      .lsu_resp  (lsu_resp),
      .alu_a     (alu_a),
      .alu_b     (alu_b),
      .lsu_req   (lsu_req),
      .stall_req (stall_req),
      .lsu_rd_m  (lsu_rd_m),
      .lsu_wen_m (lsu_wen_m)
   );

   ////////////////////////////////////////////////////////////
   // writeback merge
   ////////////////////////////////////////////////////////////

   exu_writeback u_writeback (
      .clk         (clk),
      .reset       (reset),
      .issue       (issue),
      .kill        (kill),
      .alu_res     (alu_res),
      .bru_link_pc (bru_link_pc),
      .bru_wen     (bru_wen),
      .lsu_resp    (lsu_resp),
      .lsu_rd_m    (lsu_rd_m),
      .lsu_wen_m   (lsu_wen_m),
      .rf_m        (rf_m),
      .rf_w        (rf_w)
   );

   // w stage port to the register file
   assign rf_wr = rf_w;

endmodule

//--- verilog/exu_writeback.sv
`timescale 1ns/1ps

module exu_writeback (
   input  logic                              clk,
   input  logic                              reset,
   input  exu_pkg::exu_issue_t               issue,
   input  logic                              kill,
   input  logic [exu_pkg::grlen-1:0]         alu_res,
   input  logic [exu_pkg::grlen-1:0]         bru_link_pc,
   input  logic                              bru_wen,
   input  exu_pkg::lsu_resp_t                lsu_resp,
   input  logic [exu_pkg::reg_addr_w-1:0]    lsu_rd_m,
   input  logic                              lsu_wen_m,
   output exu_pkg::rf_write_t                rf_m,
   output exu_pkg::rf_write_t                rf_w
);

   logic                              alu_wen_g;
   logic                              bru_wen_g;
   logic [exu_pkg::grlen-1:0]         alu_res_m;
   logic [exu_pkg::reg_addr_w-1:0]    rf_target_m;
   logic                              alu_wen_m;
   logic [exu_pkg::grlen-1:0]         bru_link_pc_m;
   logic                              bru_wen_m;
   logic                              wen_w;
   logic [exu_pkg::reg_addr_w-1:0]    rd_w;
   logic [exu_pkg::grlen-1:0]         data_w;

   ////////////////////////////////////////////////////////////
   // e to m
   ////////////////////////////////////////////////////////////

   // killed instruction never writes
   assign alu_wen_g = issue.alu_wen & ~kill;
   assign bru_wen_g = bru_wen & ~kill;

   // payload, no reset
   always_ff @(posedge clk) begin
      alu_res_m     <= alu_res;
      rf_target_m   <= issue.rf_target;
      bru_link_pc_m <= bru_link_pc;
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         alu_wen_m <= 1'b0;
         bru_wen_m <= 1'b0;
      end else begin
         alu_wen_m <= alu_wen_g;
         bru_wen_m <= bru_wen_g;
      end
   end

   ////////////////////////////////////////////////////////////
   // m stage merge
   ////////////////////////////////////////////////////////////

   // any unit may claim the port
   assign rf_m.wen = alu_wen_m | bru_wen_m | (lsu_wen_m & lsu_resp.data_valid);

   // branch link shares the alu target
   assign rf_m.rd = lsu_resp.data_valid ? lsu_rd_m : rf_target_m;

   // load data, else link pc, else alu result
   always_comb begin
      if (lsu_resp.data_valid) begin
         rf_m.data = lsu_resp.rdata;
      end else if (bru_wen_m) begin
         rf_m.data = bru_link_pc_m;
      end else begin
         rf_m.data = alu_res_m;
      end
   end

   ////////////////////////////////////////////////////////////
   // m to w
   ////////////////////////////////////////////////////////////

   always_ff @(posedge clk) begin
      if (reset) begin
         wen_w <= 1'b0;
      end else begin
         wen_w <= rf_m.wen;
      end
   end

   always_ff @(posedge clk) begin
      rd_w   <= rf_m.rd;
      data_w <= rf_m.data;
   end

   assign rf_w.wen  = wen_w;
   assign rf_w.rd   = rd_w;
   assign rf_w.data = data_w;

   // issue stalls behind a pending load, so the port is never contested
   a_no_port_clash: assert property (@(posedge clk) disable iff (reset)
      (alu_wen_m | bru_wen_m) |-> !lsu_resp.data_valid);

endmodule

//--- verilog/exu_trap.sv
`timescale 1ns/1ps

module exu_trap (
   input  logic                clk,
   input  logic                reset,
   input  exu_pkg::exu_issue_t issue,
   input  exu_pkg::intr_t      intr,
   input  logic                lsu_ale,
   output exu_pkg::trap_t      trap,
   output logic                kill
);

   logic prev_valid;
   logic valid_rise;
   logic intr_pend;
   logic intr_sync;

   ////////////////////////////////////////////////////////////
   // interrupt sync to instruction start
   ////////////////////////////////////////////////////////////

   always_ff @(posedge clk) begin
      if (reset) begin
         prev_valid <= 1'b0;
      end else begin
         prev_valid <= issue.valid;
      end
   end

   // first cycle of a new instruction
   assign valid_rise = issue.valid & ~prev_valid;

   // timer or external, masked by global enable
   assign intr_pend = (intr.timer | intr.ext) & intr.ie;
   assign intr_sync = intr_pend & valid_rise;

   // kill stays off the ale path, which would loop back through the lsu
   assign kill = intr_sync;

   ////////////////////////////////////////////////////////////
   // exception merge
   ////////////////////////////////////////////////////////////

   assign trap.except = issue.exception | lsu_ale | intr_sync;

   // interrupt first, faulting instruction gets replayed
   assign trap.exccode = intr_sync ? exu_pkg::exccode_int : issue.exccode;

endmodule

//--- verilog/exu_lsu_track.sv
`timescale 1ns/1ps

module exu_lsu_track (
   input  logic                                 clk,
   input  logic                                 reset,
   input  exu_pkg::exu_issue_t                  issue,
   input  logic                                 kill,
   input  exu_pkg::lsu_resp_t                   lsu_resp,
   input  logic [exu_pkg::grlen-1:0]            alu_a,
   input  logic [exu_pkg::grlen-1:0]            alu_b,
   output exu_pkg::lsu_req_t                    lsu_req,
   output logic                                 stall_req,
   output logic [exu_pkg::reg_addr_w-1:0]       lsu_rd_m,
   output logic                                 lsu_wen_m
);

   logic lsu_valid_g;
   logic lsu_fin;
   logic pending;

   ////////////////////////////////////////////////////////////
   // request
   ////////////////////////////////////////////////////////////

   // interrupt kill drops the access
   assign lsu_valid_g = issue.lsu_valid & ~kill;

   assign lsu_req.valid  = lsu_valid_g;
   assign lsu_req.base   = alu_a;
   // reg+reg form takes rs2 as offset
   assign lsu_req.offset = issue.double_read ? alu_b : issue.imm_shifted;
   assign lsu_req.wdata  = alu_b;

   ////////////////////////////////////////////////////////////
   // pending access and fetch stall
   ////////////////////////////////////////////////////////////

   // load data, store done, or faulted access aborted before the bus
   assign lsu_fin = lsu_resp.data_valid | lsu_resp.wr_fin | lsu_resp.ale;

   always_ff @(posedge clk) begin
      if (reset) begin
         pending <= 1'b0;
      end else begin
         pending <= lsu_valid_g | (pending & ~lsu_fin);
      end
   end

   // request cycle counts too, so stall starts with the issue
   assign stall_req = pending | lsu_valid_g;

   // latency varies, so hold rd and wen until the data returns
   always_ff @(posedge clk) begin
      if (lsu_valid_g) begin
         lsu_rd_m <= issue.lsu_rd;
      end
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         lsu_wen_m <= 1'b0;
      end else if (lsu_valid_g) begin
         lsu_wen_m <= issue.lsu_wen;
      end
   end

   // fetch must hold issue while an access is in flight
   a_no_req_while_pending: assert property (@(posedge clk) disable iff (reset)
      lsu_valid_g |-> !pending);

   a_no_fin_when_idle: assert property (@(posedge clk) disable iff (reset)
      lsu_fin |-> pending);

endmodule

//--- verilog/exu_bypass.sv
`timescale 1ns/1ps

module exu_bypass (
   input  exu_pkg::exu_issue_t           issue,
   input  exu_pkg::rf_write_t            rf_m,
   input  exu_pkg::rf_write_t            rf_w,
   output logic [exu_pkg::grlen-1:0]     alu_a,
   output logic [exu_pkg::grlen-1:0]     alu_b
);

   // stage hit: write enabled, same index, not r0
   function automatic logic fwd_hit(
      input logic [exu_pkg::reg_addr_w-1:0] rs,
      input exu_pkg::rf_write_t             st
   );
      return st.wen && (rs != '0) && (rs == st.rd);
   endfunction

   logic rs1_sel_m;
   logic rs1_sel_w;
   logic rs1_sel_rf;
   logic rs2_sel_m;
   logic rs2_sel_w;
   logic rs2_sel_rf;
   logic rs2_use_other;

   ////////////////////////////////////////////////////////////
   // select generation
   ////////////////////////////////////////////////////////////

   // m over w over register file
   assign rs1_sel_m  = fwd_hit(issue.rs1, rf_m);
   assign rs1_sel_w  = ~rs1_sel_m & fwd_hit(issue.rs1, rf_w);
   assign rs1_sel_rf = ~rs1_sel_m & ~rs1_sel_w;

   // immediate or rs2-offset keeps b on rf_b
   assign rs2_use_other = issue.b_imm | issue.double_read;

   assign rs2_sel_m  = ~rs2_use_other & fwd_hit(issue.rs2, rf_m);
   assign rs2_sel_w  = ~rs2_use_other & ~rs2_sel_m & fwd_hit(issue.rs2, rf_w);
   assign rs2_sel_rf = ~rs2_sel_m & ~rs2_sel_w;

   ////////////////////////////////////////////////////////////
   // and-or operand muxes
   ////////////////////////////////////////////////////////////

   always_comb begin
      alu_a = ({exu_pkg::grlen{rs1_sel_rf}} & issue.rf_a)
            | ({exu_pkg::grlen{rs1_sel_m}}  & rf_m.data)
            | ({exu_pkg::grlen{rs1_sel_w}}  & rf_w.data);
      alu_b = ({exu_pkg::grlen{rs2_sel_rf}} & issue.rf_b)
            | ({exu_pkg::grlen{rs2_sel_m}}  & rf_m.data)
            | ({exu_pkg::grlen{rs2_sel_w}}  & rf_w.data);
   end

endmodule

//--- verilog/exu_pkg.sv
package exu_pkg;

   ////////////////////////////////////////////////////////////
   // architectural widths
   ////////////////////////////////////////////////////////////

   // general register width
   localparam int grlen = 32;
   // register index width
   localparam int reg_addr_w = 5;
   // exception code width
   localparam int exccode_w = 6;

   // interrupt code, wins over any other exception
   localparam logic [exccode_w-1:0] exccode_int = '0;

   ////////////////////////////////////////////////////////////
   // pipeline bundles
   ////////////////////////////////////////////////////////////

   // decoded instruction at execute
   typedef struct packed {
      logic                  valid;
      logic [reg_addr_w-1:0] rs1;
      logic [reg_addr_w-1:0] rs2;
      logic [grlen-1:0]      rf_a;
      logic [grlen-1:0]      rf_b;
      // operand b is an immediate
      logic                  b_imm;
      // ld/st offset comes from rs2
      logic                  double_read;
      logic [grlen-1:0]      imm_shifted;
      logic [reg_addr_w-1:0] rf_target;
      logic                  alu_wen;
      logic                  bru_valid;
      logic                  lsu_valid;
      logic [reg_addr_w-1:0] lsu_rd;
      logic                  lsu_wen;
      logic                  exception;
      logic [exccode_w-1:0]  exccode;
   } exu_issue_t;

   // one register file write port
   typedef struct packed {
      logic                  wen;
      logic [reg_addr_w-1:0] rd;
      logic [grlen-1:0]      data;
   } rf_write_t;

   typedef struct packed {
      logic             valid;
      logic [grlen-1:0] base;
      logic [grlen-1:0] offset;
      logic [grlen-1:0] wdata;
   } lsu_req_t;

   typedef struct packed {
      // load data ready
      logic             data_valid;
      // store done
      logic             wr_fin;
      // alignment fault
      logic             ale;
      logic [grlen-1:0] rdata;
   } lsu_resp_t;

   typedef struct packed {
      logic timer;
      logic ext;
      logic ie;
   } intr_t;

   // report to fetch
   typedef struct packed {
      logic                 except;
      logic [exccode_w-1:0] exccode;
   } trap_t;

endpackage
